//--- common/uncore_pkg.sv
package uncore_pkg;

  localparam int ADDR_W    = 32;
  localparam int DATA_W    = 64;
  localparam int NUM_SRC   = 2;
  localparam int NUM_SINK  = 3;
  localparam int SRC_ID_W  = 1;
  localparam int SINK_ID_W = 2;

  // Sink order on the command crossbar
  localparam logic [SINK_ID_W-1:0] SINK_CFG   = 2'd0;
  localparam logic [SINK_ID_W-1:0] SINK_CLINT = 2'd1;
  localparam logic [SINK_ID_W-1:0] SINK_MEM   = 2'd2;

  localparam logic [ADDR_W-1:0] DRAM_BASE = 32'h8000_0000;

  // Device field of a local address, bits 23:20
  localparam int DEV_LSB = 20;
  localparam int DEV_W   = 4;

  localparam logic [DEV_W-1:0] CFG_DEV   = 4'd1;
  localparam logic [DEV_W-1:0] CLINT_DEV = 4'd2;

  localparam logic [DEV_LSB-1:0] CFG_FREEZE_OFS  = 20'h0_0000;
  localparam logic [DEV_LSB-1:0] CFG_SCRATCH_OFS = 20'h0_0008;

  localparam logic [DEV_LSB-1:0] CLINT_MSIP_OFS     = 20'h0_0000;
  localparam logic [DEV_LSB-1:0] CLINT_MTIMECMP_OFS = 20'h0_4000;
  localparam logic [DEV_LSB-1:0] CLINT_MTIME_OFS    = 20'h0_BFF8;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } mem_op_e;

  typedef struct packed {
    mem_op_e             op;
    logic [ADDR_W-1:0]   addr;
    logic [DATA_W-1:0]   data;
  } cmd_req_s;

  typedef struct packed {
    cmd_req_s            req;
    logic [SRC_ID_W-1:0] src_id;
  } cmd_msg_s;

  typedef struct packed {
    mem_op_e             op;
    logic [ADDR_W-1:0]   addr;
    logic [DATA_W-1:0]   data;
    logic [SRC_ID_W-1:0] src_id;
  } resp_msg_s;

endpackage

//--- xbar/rr_arbiter.sv
`timescale 1ns/10ps

module rr_arbiter #(
  parameter int N = 2
) (
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic [N-1:0] req_i,
  input  logic         ack_i,
  output logic [N-1:0] grant_o
);

  localparam int PTR_W = (N > 1) ? $clog2(N) : 1;

  logic [PTR_W-1:0] ptr_q;
  logic [PTR_W-1:0] win_idx;
  logic             any_req;

  // Scan from the far end so the requester nearest the pointer is kept
  always_comb
  begin
    win_idx = ptr_q;
    any_req = 1'b0;
    for (int k = N - 1; k >= 0; k--)
    begin
      if (req_i[(int'(ptr_q) + k) % N])
      begin
        win_idx = PTR_W'((int'(ptr_q) + k) % N);
        any_req = 1'b1;
      end
    end
    grant_o = '0;
    if (any_req)
      grant_o[win_idx] = 1'b1;
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      ptr_q <= '0;
    else if (ack_i)
      ptr_q <= (int'(win_idx) == N - 1) ? '0 : win_idx + 1'b1;
  end

  // A requester left waiting at a transfer goes ahead of the winner next
  a_grant_moves: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ack_i && |(req_i & ~grant_o) |=> grant_o != $past(grant_o));

endmodule

//--- xbar/msg_xbar.sv
`timescale 1ns/10ps

module msg_xbar #(
  parameter int NUM_IN  = 2,
  parameter int NUM_OUT = 3,
  parameter type msg_t  = logic,
  localparam int DST_W  = (NUM_OUT > 1) ? $clog2(NUM_OUT) : 1
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,

  input  msg_t [NUM_IN-1:0]              in_msg_i,
  input  logic [NUM_IN-1:0][DST_W-1:0]   in_dst_i,
  input  logic [NUM_IN-1:0]              in_v_i,
  output logic [NUM_IN-1:0]              in_ready_o,

  output msg_t [NUM_OUT-1:0]             out_msg_o,
  output logic [NUM_OUT-1:0]             out_v_o,
  input  logic [NUM_OUT-1:0]             out_ready_i
);

  // Grants seen per output and the same grants seen per input
  logic [NUM_OUT-1:0][NUM_IN-1:0] out_grant;
  logic [NUM_IN-1:0][NUM_OUT-1:0] in_grant;

  for (genvar o = 0; o < NUM_OUT; o++)
  begin : g_out
    logic [NUM_IN-1:0] req;
    msg_t              sel_msg;

    for (genvar i = 0; i < NUM_IN; i++)
    begin : g_req
      assign req[i]         = in_v_i[i] && (in_dst_i[i] == DST_W'(o));
      assign in_grant[i][o] = out_grant[o][i];
    end

    rr_arbiter #(
      .N(NUM_IN)
    ) u_arb (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .req_i   (req),
      .ack_i   (out_v_o[o] && out_ready_i[o]),
      .grant_o (out_grant[o])
    );

    always_comb
    begin
      sel_msg = in_msg_i[0];
      for (int i = 0; i < NUM_IN; i++)
      begin
        if (out_grant[o][i])
          sel_msg = in_msg_i[i];
      end
    end

    assign out_msg_o[o] = sel_msg;
    assign out_v_o[o]   = |out_grant[o];
  end

  // Only the winner sees the sink's ready
  for (genvar i = 0; i < NUM_IN; i++)
  begin : g_in
    assign in_ready_o[i] = |(in_grant[i] & out_ready_i);

    a_single_grant: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(in_grant[i]));
  end

endmodule

//--- src/addr_decode.sv
`timescale 1ns/10ps

module addr_decode #(
  parameter int NUM_IN = 2
) (
  input  uncore_pkg::cmd_req_s [NUM_IN-1:0]                    req_i,
  output uncore_pkg::cmd_msg_s [NUM_IN-1:0]                    msg_o,
  output logic [NUM_IN-1:0][uncore_pkg::SINK_ID_W-1:0]         dst_o
);

  import uncore_pkg::*;

  for (genvar i = 0; i < NUM_IN; i++)
  begin : g_src
    logic             is_local;
    logic [DEV_W-1:0] dev;

    assign is_local = req_i[i].addr < DRAM_BASE;
    assign dev      = req_i[i].addr[DEV_LSB +: DEV_W];

    // Unknown local devices fall through to memory
    always_comb
    begin
      if (is_local && (dev == CFG_DEV))
        dst_o[i] = SINK_CFG;
      else if (is_local && (dev == CLINT_DEV))
        dst_o[i] = SINK_CLINT;
      else
        dst_o[i] = SINK_MEM;
    end

    assign msg_o[i].req    = req_i[i];
    assign msg_o[i].src_id = SRC_ID_W'(i);
  end

endmodule

//--- devices/cfg_regs.sv
`timescale 1ns/10ps

module cfg_regs (
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  input  uncore_pkg::cmd_msg_s  cmd_i,
  input  logic                  cmd_v_i,
  output logic                  cmd_ready_o,

  output uncore_pkg::resp_msg_s resp_o,
  output logic                  resp_v_o,
  input  logic                  resp_ready_i,

  output logic                  freeze_o
);

  import uncore_pkg::*;

  logic               resp_v_q;
  resp_msg_s          resp_q;
  logic               freeze_q;
  logic [DATA_W-1:0]  scratch_q;
  logic [DEV_LSB-1:0] ofs;
  logic [DATA_W-1:0]  rdata;
  logic               cmd_fire;
  logic               is_write;

  // A new command waits until the one response slot drains
  assign cmd_ready_o = !resp_v_q;
  assign cmd_fire    = cmd_v_i && cmd_ready_o;
  assign ofs         = cmd_i.req.addr[DEV_LSB-1:0];
  assign is_write    = cmd_i.req.op == OP_WRITE;

  always_comb
  begin
    case (ofs)
      CFG_FREEZE_OFS:  rdata = DATA_W'(freeze_q);
      CFG_SCRATCH_OFS: rdata = scratch_q;
      default:         rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      resp_v_q  <= 1'b0;
      freeze_q  <= 1'b1;
      scratch_q <= '0;
    end
    else
    begin
      if (cmd_fire)
        resp_v_q <= 1'b1;
      else if (resp_ready_i)
        resp_v_q <= 1'b0;

      if (cmd_fire && is_write && (ofs == CFG_FREEZE_OFS))
        freeze_q <= cmd_i.req.data[0];
      if (cmd_fire && is_write && (ofs == CFG_SCRATCH_OFS))
        scratch_q <= cmd_i.req.data;
    end
  end

  // Writes answer with zero data
  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
    begin
      resp_q.op     <= cmd_i.req.op;
      resp_q.addr   <= cmd_i.req.addr;
      resp_q.data   <= is_write ? '0 : rdata;
      resp_q.src_id <= cmd_i.src_id;
    end
  end

  assign resp_o   = resp_q;
  assign resp_v_o = resp_v_q;
  assign freeze_o = freeze_q;

  a_resp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    resp_v_o && !resp_ready_i |=> resp_v_o && $stable(resp_o));

endmodule

//--- devices/clint.sv
`timescale 1ns/10ps

module clint (
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  input  uncore_pkg::cmd_msg_s  cmd_i,
  input  logic                  cmd_v_i,
  output logic                  cmd_ready_o,

  output uncore_pkg::resp_msg_s resp_o,
  output logic                  resp_v_o,
  input  logic                  resp_ready_i,

  output logic                  timer_irq_o,
  output logic                  software_irq_o
);

  import uncore_pkg::*;

  logic               resp_v_q;
  resp_msg_s          resp_q;
  logic               msip_q;
  logic [DATA_W-1:0]  mtimecmp_q;
  logic [DATA_W-1:0]  mtime_q;
  logic [DEV_LSB-1:0] ofs;
  logic [DATA_W-1:0]  rdata;
  logic               cmd_fire;
  logic               wr_fire;

  assign cmd_ready_o = !resp_v_q;
  assign cmd_fire    = cmd_v_i && cmd_ready_o;
  assign wr_fire     = cmd_fire && (cmd_i.req.op == OP_WRITE);
  assign ofs         = cmd_i.req.addr[DEV_LSB-1:0];

  always_comb
  begin
    case (ofs)
      CLINT_MSIP_OFS:     rdata = DATA_W'(msip_q);
      CLINT_MTIMECMP_OFS: rdata = mtimecmp_q;
      CLINT_MTIME_OFS:    rdata = mtime_q;
      default:            rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      resp_v_q   <= 1'b0;
      msip_q     <= 1'b0;
      mtimecmp_q <= '1;
      mtime_q    <= '0;
    end
    else
    begin
      if (cmd_fire)
        resp_v_q <= 1'b1;
      else if (resp_ready_i)
        resp_v_q <= 1'b0;

      if (wr_fire && (ofs == CLINT_MSIP_OFS))
        msip_q <= cmd_i.req.data[0];
      if (wr_fire && (ofs == CLINT_MTIMECMP_OFS))
        mtimecmp_q <= cmd_i.req.data;

      // A write to mtime takes the place of this cycle's tick
      if (wr_fire && (ofs == CLINT_MTIME_OFS))
        mtime_q <= cmd_i.req.data;
      else
        mtime_q <= mtime_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
    begin
      resp_q.op     <= cmd_i.req.op;
      resp_q.addr   <= cmd_i.req.addr;
      resp_q.data   <= (cmd_i.req.op == OP_WRITE) ? '0 : rdata;
      resp_q.src_id <= cmd_i.src_id;
    end
  end

  assign resp_o         = resp_q;
  assign resp_v_o       = resp_v_q;
  assign timer_irq_o    = mtime_q >= mtimecmp_q;
  assign software_irq_o = msip_q;

  a_resp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    resp_v_o && !resp_ready_i |=> resp_v_o && $stable(resp_o));

endmodule

//--- src/uncore_top.sv
`timescale 1ns/10ps

module uncore_top (
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  input  uncore_pkg::cmd_req_s  proc_cmd_i,
  input  logic                  proc_cmd_v_i,
  output logic                  proc_cmd_ready_o,
  output uncore_pkg::resp_msg_s proc_resp_o,
  output logic                  proc_resp_v_o,
  input  logic                  proc_resp_ready_i,

  input  uncore_pkg::cmd_req_s  io_cmd_i,
  input  logic                  io_cmd_v_i,
  output logic                  io_cmd_ready_o,
  output uncore_pkg::resp_msg_s io_resp_o,
  output logic                  io_resp_v_o,
  input  logic                  io_resp_ready_i,

  output uncore_pkg::cmd_msg_s  mem_cmd_o,
  output logic                  mem_cmd_v_o,
  input  logic                  mem_cmd_ready_i,
  input  uncore_pkg::resp_msg_s mem_resp_i,
  input  logic                  mem_resp_v_i,
  output logic                  mem_resp_ready_o,

  output logic                  freeze_o,
  output logic                  timer_irq_o,
  output logic                  software_irq_o
);

  import uncore_pkg::*;

  // Source 0 is the processor, source 1 the incoming I/O port
  cmd_req_s  [NUM_SRC-1:0]                src_req;
  cmd_msg_s  [NUM_SRC-1:0]                src_msg;
  logic      [NUM_SRC-1:0][SINK_ID_W-1:0] src_dst;
  logic      [NUM_SRC-1:0]                src_cmd_v;
  logic      [NUM_SRC-1:0]                src_cmd_ready;
  resp_msg_s [NUM_SRC-1:0]                src_resp;
  logic      [NUM_SRC-1:0]                src_resp_v;
  logic      [NUM_SRC-1:0]                src_resp_ready;

  cmd_msg_s  [NUM_SINK-1:0]               sink_cmd;
  logic      [NUM_SINK-1:0]               sink_cmd_v;
  logic      [NUM_SINK-1:0]               sink_cmd_ready;
  resp_msg_s [NUM_SINK-1:0]               sink_resp;
  logic      [NUM_SINK-1:0][SRC_ID_W-1:0] sink_resp_dst;
  logic      [NUM_SINK-1:0]               sink_resp_v;
  logic      [NUM_SINK-1:0]               sink_resp_ready;

  assign src_req          = {io_cmd_i, proc_cmd_i};
  assign src_cmd_v        = {io_cmd_v_i, proc_cmd_v_i};
  assign proc_cmd_ready_o = src_cmd_ready[0];
  assign io_cmd_ready_o   = src_cmd_ready[1];

  assign proc_resp_o      = src_resp[0];
  assign proc_resp_v_o    = src_resp_v[0];
  assign io_resp_o        = src_resp[1];
  assign io_resp_v_o      = src_resp_v[1];
  assign src_resp_ready   = {io_resp_ready_i, proc_resp_ready_i};

  assign mem_cmd_o                  = sink_cmd[SINK_MEM];
  assign mem_cmd_v_o                = sink_cmd_v[SINK_MEM];
  assign sink_cmd_ready[SINK_MEM]   = mem_cmd_ready_i;
  assign sink_resp[SINK_MEM]        = mem_resp_i;
  assign sink_resp_v[SINK_MEM]      = mem_resp_v_i;
  assign mem_resp_ready_o           = sink_resp_ready[SINK_MEM];

  // Responses go back to whichever source the id names
  for (genvar s = 0; s < NUM_SINK; s++)
  begin : g_resp_dst
    assign sink_resp_dst[s] = sink_resp[s].src_id;
  end

  addr_decode #(.NUM_IN(NUM_SRC)) u_decode (
    .req_i (src_req),
    .msg_o (src_msg),
    .dst_o (src_dst)
  );

  msg_xbar #(.NUM_IN(NUM_SRC), .NUM_OUT(NUM_SINK), .msg_t(cmd_msg_s)) u_cmd_xbar (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_msg_i    (src_msg),
    .in_dst_i    (src_dst),
    .in_v_i      (src_cmd_v),
    .in_ready_o  (src_cmd_ready),
    .out_msg_o   (sink_cmd),
    .out_v_o     (sink_cmd_v),
    .out_ready_i (sink_cmd_ready)
  );

  msg_xbar #(.NUM_IN(NUM_SINK), .NUM_OUT(NUM_SRC), .msg_t(resp_msg_s)) u_resp_xbar (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_msg_i    (sink_resp),
    .in_dst_i    (sink_resp_dst),
    .in_v_i      (sink_resp_v),
    .in_ready_o  (sink_resp_ready),
    .out_msg_o   (src_resp),
    .out_v_o     (src_resp_v),
    .out_ready_i (src_resp_ready)
  );

  cfg_regs u_cfg (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .cmd_i        (sink_cmd[SINK_CFG]),
    .cmd_v_i      (sink_cmd_v[SINK_CFG]),
    .cmd_ready_o  (sink_cmd_ready[SINK_CFG]),
    .resp_o       (sink_resp[SINK_CFG]),
    .resp_v_o     (sink_resp_v[SINK_CFG]),
    .resp_ready_i (sink_resp_ready[SINK_CFG]),
    .freeze_o     (freeze_o)
  );

  clint u_clint (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .cmd_i          (sink_cmd[SINK_CLINT]),
    .cmd_v_i        (sink_cmd_v[SINK_CLINT]),
    .cmd_ready_o    (sink_cmd_ready[SINK_CLINT]),
    .resp_o         (sink_resp[SINK_CLINT]),
    .resp_v_o       (sink_resp_v[SINK_CLINT]),
    .resp_ready_i   (sink_resp_ready[SINK_CLINT]),
    .timer_irq_o    (timer_irq_o),
    .software_irq_o (software_irq_o)
  );

endmodule

//--- dv/tb_checker.sv
`timescale 1ns/10ps

module tb_checker (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  uncore_pkg::cmd_req_s  proc_cmd_i,
  input  logic                  proc_cmd_v_i,
  input  logic                  proc_cmd_ready_i,
  input  uncore_pkg::resp_msg_s proc_resp_i,
  input  logic                  proc_resp_v_i,
  input  logic                  proc_resp_ready_i,
  input  uncore_pkg::cmd_req_s  io_cmd_i,
  input  logic                  io_cmd_v_i,
  input  logic                  io_cmd_ready_i,
  input  uncore_pkg::resp_msg_s io_resp_i,
  input  logic                  io_resp_v_i,
  input  logic                  io_resp_ready_i,
  input  uncore_pkg::cmd_msg_s  mem_cmd_i,
  input  logic                  mem_cmd_v_i,
  input  logic                  mem_cmd_ready_i,
  input  logic                  freeze_i,
  input  logic                  timer_irq_i,
  input  logic                  software_irq_i,
  output int                    err_cnt_o,
  output int                    resp_cnt_o
);

  import uncore_pkg::*;

  logic [1:0]        pend_v;
  cmd_req_s          pend_cmd [2];
  logic [DATA_W-1:0] pend_data [2];
  logic [1:0]        pend_mtime;
  logic              model_freeze;
  logic [DATA_W-1:0] model_scratch;
  logic              model_msip;
  logic [DATA_W-1:0] model_mtimecmp;
  logic [DATA_W-1:0] last_mtime;
  logic [DATA_W-1:0] mem_model [logic [ADDR_W-1:0]];

  task automatic check_val(string name, logic [DATA_W-1:0] exp, logic [DATA_W-1:0] act);
    if (exp !== act)
    begin
      $display("FAIL %0t %s expected %0h actual %0h", $time, name, exp, act);
      err_cnt_o++;
    end
  endtask

  task automatic report(string what);
    $display("ERROR at %0t: %s", $time, what);
    err_cnt_o++;
  endtask

  task automatic check_mem_cmd(cmd_req_s exp);
    check_val("mem_cmd_o.op", 64'(exp.op), 64'(mem_cmd_i.req.op));
    check_val("mem_cmd_o.addr", 64'(exp.addr), 64'(mem_cmd_i.req.addr));
    check_val("mem_cmd_o.data", exp.data, mem_cmd_i.req.data);
  endtask

  // Model update happens in acceptance order, which is the device order too
  task automatic take_cmd(int src, cmd_req_s cmd);
    logic [DEV_W-1:0]   dev;
    logic [DEV_LSB-1:0] ofs;
    logic               wr;
    dev = cmd.addr[DEV_LSB +: DEV_W];
    ofs = cmd.addr[DEV_LSB-1:0];
    wr  = cmd.op == OP_WRITE;
    pend_v[src]     = 1'b1;
    pend_cmd[src]   = cmd;
    pend_data[src]  = '0;
    pend_mtime[src] = 1'b0;
    if (cmd.addr >= DRAM_BASE || (dev != CFG_DEV && dev != CLINT_DEV))
    begin
      if (wr)
        mem_model[cmd.addr] = cmd.data;
      else if (mem_model.exists(cmd.addr))
        pend_data[src] = mem_model[cmd.addr];
    end
    else if (dev == CFG_DEV)
    begin
      if (ofs == CFG_FREEZE_OFS && wr)
        model_freeze = cmd.data[0];
      else if (ofs == CFG_FREEZE_OFS)
        pend_data[src] = {63'd0, model_freeze};
      else if (ofs == CFG_SCRATCH_OFS && wr)
        model_scratch = cmd.data;
      else if (ofs == CFG_SCRATCH_OFS)
        pend_data[src] = model_scratch;
    end
    else
    begin
      if (ofs == CLINT_MSIP_OFS && wr)
        model_msip = cmd.data[0];
      else if (ofs == CLINT_MSIP_OFS)
        pend_data[src] = {63'd0, model_msip};
      else if (ofs == CLINT_MTIMECMP_OFS && wr)
        model_mtimecmp = cmd.data;
      else if (ofs == CLINT_MTIMECMP_OFS)
        pend_data[src] = model_mtimecmp;
      else if (ofs == CLINT_MTIME_OFS && !wr)
        pend_mtime[src] = 1'b1;
    end
  endtask

  task automatic take_resp(int src, resp_msg_s resp, string port);
    check_val({port, ".op"}, 64'(pend_cmd[src].op), 64'(resp.op));
    check_val({port, ".addr"}, 64'(pend_cmd[src].addr), 64'(resp.addr));
    check_val({port, ".src_id"}, 64'(src), 64'(resp.src_id));
    if (pend_mtime[src])
    begin
      if (resp.data < last_mtime)
        report("mtime read went backwards");
      last_mtime = resp.data;
    end
    else
      check_val({port, ".data"}, pend_data[src], resp.data);
    pend_v[src] = 1'b0;
  endtask

  // Every response handshake at a port is counted, expected or not
  task automatic watch_resp(int src, logic v, logic rdy, resp_msg_s resp, string port);
    if (v && rdy)
      resp_cnt_o++;
    if (v && !pend_v[src])
      report({"response at ", port, " with no command outstanding"});
    else if (v && rdy)
      take_resp(src, resp, port);
  endtask

  // Sampled at the falling edge, a handshake seen here completes at the next rising edge
  always @(negedge clk_i)
  begin
    if (!rst_n_i)
    begin
      pend_v         = '0;
      model_freeze   = 1'b1;
      model_scratch  = '0;
      model_msip     = 1'b0;
      model_mtimecmp = '1;
      last_mtime     = '0;
      err_cnt_o      = 0;
      resp_cnt_o     = 0;
    end
    else
    begin
      check_val("freeze_o", 64'(model_freeze), 64'(freeze_i));
      check_val("software_irq_o", 64'(model_msip), 64'(software_irq_i));
      if (model_mtimecmp == '1)
        check_val("timer_irq_o", 64'd0, 64'(timer_irq_i));
      watch_resp(0, proc_resp_v_i, proc_resp_ready_i, proc_resp_i, "proc_resp_o");
      watch_resp(1, io_resp_v_i, io_resp_ready_i, io_resp_i, "io_resp_o");
      if (mem_cmd_v_i && mem_cmd_ready_i)
      begin
        if (mem_cmd_i.src_id == 1'b0 && proc_cmd_v_i && proc_cmd_ready_i)
          check_mem_cmd(proc_cmd_i);
        else if (mem_cmd_i.src_id == 1'b1 && io_cmd_v_i && io_cmd_ready_i)
          check_mem_cmd(io_cmd_i);
        else
          report("memory command carries the id of a source that sent nothing");
      end
      if (proc_cmd_v_i && proc_cmd_ready_i)
        take_cmd(0, proc_cmd_i);
      if (io_cmd_v_i && io_cmd_ready_i)
        take_cmd(1, io_cmd_i);
    end
  end

endmodule

//--- dv/tb_uncore.sv
`timescale 1ns/10ps

module tb_uncore;

  import uncore_pkg::*;

  localparam int N_CFG   = 20;
  localparam int N_MEM   = 20;
  localparam int N_SHR   = 12;
  localparam int N_CLINT = 10;
  localparam int N_CMDS  = 2 * N_CFG + 2 * N_MEM + 2 * N_SHR + N_CLINT;
  localparam int LIMIT   = N_CMDS * 40 + 200;

  localparam logic [ADDR_W-1:0] CFG_BASE   = 32'h0010_0000;
  localparam logic [ADDR_W-1:0] CLINT_BASE = 32'h0020_0000;

  logic      clk;
  logic      rst_n;
  cmd_req_s  proc_cmd;
  logic      proc_cmd_v;
  logic      proc_cmd_ready;
  resp_msg_s proc_resp;
  logic      proc_resp_v;
  logic      proc_resp_ready;
  cmd_req_s  io_cmd;
  logic      io_cmd_v;
  logic      io_cmd_ready;
  resp_msg_s io_resp;
  logic      io_resp_v;
  logic      io_resp_ready;
  cmd_msg_s  mem_cmd;
  logic      mem_cmd_v;
  logic      mem_cmd_ready;
  resp_msg_s mem_resp;
  logic      mem_resp_v;
  logic      mem_resp_ready;
  logic      freeze;
  logic      timer_irq;
  logic      software_irq;
  int        chk_errs;
  int        chk_resps;
  int        tb_errs;
  int        n_tests;
  int        n_pass;
  int        cycles;
  logic [31:0] lfsr_q = 32'd81084;
  logic [DATA_W-1:0] mem_store [logic [ADDR_W-1:0]];

  uncore_top DUT (
    .clk_i (clk), .rst_n_i (rst_n),
    .proc_cmd_i (proc_cmd), .proc_cmd_v_i (proc_cmd_v), .proc_cmd_ready_o (proc_cmd_ready),
    .proc_resp_o (proc_resp), .proc_resp_v_o (proc_resp_v),
    .proc_resp_ready_i (proc_resp_ready),
    .io_cmd_i (io_cmd), .io_cmd_v_i (io_cmd_v), .io_cmd_ready_o (io_cmd_ready),
    .io_resp_o (io_resp), .io_resp_v_o (io_resp_v), .io_resp_ready_i (io_resp_ready),
    .mem_cmd_o (mem_cmd), .mem_cmd_v_o (mem_cmd_v), .mem_cmd_ready_i (mem_cmd_ready),
    .mem_resp_i (mem_resp), .mem_resp_v_i (mem_resp_v), .mem_resp_ready_o (mem_resp_ready),
    .freeze_o (freeze), .timer_irq_o (timer_irq), .software_irq_o (software_irq)
  );

  tb_checker u_chk (
    .clk_i (clk), .rst_n_i (rst_n),
    .proc_cmd_i (proc_cmd), .proc_cmd_v_i (proc_cmd_v), .proc_cmd_ready_i (proc_cmd_ready),
    .proc_resp_i (proc_resp), .proc_resp_v_i (proc_resp_v),
    .proc_resp_ready_i (proc_resp_ready),
    .io_cmd_i (io_cmd), .io_cmd_v_i (io_cmd_v), .io_cmd_ready_i (io_cmd_ready),
    .io_resp_i (io_resp), .io_resp_v_i (io_resp_v), .io_resp_ready_i (io_resp_ready),
    .mem_cmd_i (mem_cmd), .mem_cmd_v_i (mem_cmd_v), .mem_cmd_ready_i (mem_cmd_ready),
    .freeze_i (freeze), .timer_irq_i (timer_irq), .software_irq_i (software_irq),
    .err_cnt_o (chk_errs), .resp_cnt_o (chk_resps)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Fibonacci LFSR with taps 32, 22, 2, 1
  function automatic logic [63:0] rand_bits(int n);
    logic [63:0] val;
    logic        fb;
    val = '0;
    for (int k = 0; k < n; k++)
    begin
      fb    = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val   = {val[62:0], fb};
    end
    return val;
  endfunction

  function automatic logic cmd_ready(int src);
    return (src == 0) ? proc_cmd_ready : io_cmd_ready;
  endfunction

  function automatic logic resp_done(int src);
    if (src == 0)
      return proc_resp_v && proc_resp_ready;
    return io_resp_v && io_resp_ready;
  endfunction

  task automatic expect_bit(string name, logic exp, logic act);
    if (exp !== act)
    begin
      $display("FAIL %0t %s expected %0h actual %0h", $time, name, exp, act);
      tb_errs++;
    end
  endtask

  // One command, held until accepted, then wait for its response
  task automatic issue(int src, mem_op_e op, logic [31:0] addr, logic [63:0] data);
    cmd_req_s c;
    c.op   = op;
    c.addr = addr;
    c.data = data;
    @(posedge clk);
    #1;
    if (src == 0)
    begin
      proc_cmd   = c;
      proc_cmd_v = 1'b1;
    end
    else
    begin
      io_cmd   = c;
      io_cmd_v = 1'b1;
    end
    @(negedge clk);
    while (!cmd_ready(src))
      @(negedge clk);
    @(posedge clk);
    #1;
    if (src == 0)
      proc_cmd_v = 1'b0;
    else
      io_cmd_v = 1'b0;
    @(negedge clk);
    while (!resp_done(src))
      @(negedge clk);
    @(posedge clk);
  endtask

  // Kind 0 is cfg, 1 memory, 2 mixed cfg and clint traffic
  task automatic run_source(int src, int n, int kind);
    logic [63:0] r;
    logic [63:0] d;
    logic [31:0] addr;
    logic [3:0]  dev;
    mem_op_e     op;
    for (int i = 0; i < n; i++)
    begin
      r    = rand_bits(6);
      d    = rand_bits(64);
      op   = mem_op_e'(r[0]);
      addr = CFG_BASE;
      if (kind == 0)
        addr = CFG_BASE | ((r[2:1] == 2'd2) ? 32'h8 : (r[2:1] == 2'd3) ? 32'h10 : 32'h0);
      else if (kind == 1 && r[1])
        addr = DRAM_BASE | {26'd0, r[4:2], 3'd0};
      else if (kind == 1)
      begin
        dev  = (r[3:2] == 2'd0) ? 4'd0 : 4'(r[3:2]) + 4'd2;
        addr = {8'd0, dev, 14'd0, r[5:4], 4'd0};
      end
      else if (r[2:1] == 2'd1)
        addr = CLINT_BASE | 32'h4000;
      else if (r[2:1] == 2'd2)
      begin
        addr = CLINT_BASE | 32'hBFF8;
        op   = OP_READ;
      end
      else if (r[2:1] == 2'd3)
        addr = CLINT_BASE;
      else
        addr = CFG_BASE | 32'h8;
      issue(src, op, addr, d);
    end
  endtask

  task automatic finish_test(string name, int base);
    int now;
    now = tb_errs + chk_errs;
    n_tests++;
    if (now == base)
    begin
      n_pass++;
      $display("test %s: passed", name);
    end
    else
      $display("test %s: failed with %0d errors", name, now - base);
  endtask

  initial
  begin : mem_responder
    logic [63:0] r;
    cmd_msg_s    c;
    resp_msg_s   rsp;
    forever
    begin
      @(negedge clk);
      if (rst_n && mem_cmd_v && mem_cmd_ready)
      begin
        c = mem_cmd;
        @(posedge clk);
        #1;
        mem_cmd_ready = 1'b0;
        r = rand_bits(3);
        repeat (r[2:0]) @(posedge clk);
        #1;
        rsp.op     = c.req.op;
        rsp.addr   = c.req.addr;
        rsp.src_id = c.src_id;
        rsp.data   = '0;
        if (c.req.op == OP_WRITE)
          mem_store[c.req.addr] = c.req.data;
        else if (mem_store.exists(c.req.addr))
          rsp.data = mem_store[c.req.addr];
        mem_resp   = rsp;
        mem_resp_v = 1'b1;
        @(negedge clk);
        while (!mem_resp_ready)
          @(negedge clk);
        @(posedge clk);
        #1;
        mem_resp_v    = 1'b0;
        mem_cmd_ready = 1'b1;
      end
    end
  end

  initial
  begin : resp_ready_driver
    logic [63:0] r;
    forever
    begin
      @(posedge clk);
      #1;
      r = rand_bits(4);
      proc_resp_ready = r[1:0] != 2'd0;
      io_resp_ready   = r[3:2] != 2'd0;
    end
  end

  initial
  begin
    cycles = 0;
    while (cycles < LIMIT)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", LIMIT);
    $display("RESULT: FAIL");
    $finish;
  end

  initial
  begin : test_seq
    int  base;
    int  resps;
    logic risen;
    rst_n = 1'b0;
    proc_cmd = '0;
    proc_cmd_v = 1'b0;
    proc_resp_ready = 1'b0;
    io_cmd = '0;
    io_cmd_v = 1'b0;
    io_resp_ready = 1'b0;
    mem_cmd_ready = 1'b1;
    mem_resp = '0;
    mem_resp_v = 1'b0;
    tb_errs = 0;
    n_tests = 0;
    n_pass = 0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    base = tb_errs + chk_errs;
    @(negedge clk);
    expect_bit("proc_resp_v_o", 1'b0, proc_resp_v);
    expect_bit("io_resp_v_o", 1'b0, io_resp_v);
    expect_bit("mem_cmd_v_o", 1'b0, mem_cmd_v);
    expect_bit("freeze_o", 1'b1, freeze);
    expect_bit("timer_irq_o", 1'b0, timer_irq);
    expect_bit("software_irq_o", 1'b0, software_irq);
    finish_test("reset_state", base);

    base = tb_errs + chk_errs;
    fork
      run_source(0, N_CFG, 0);
      run_source(1, N_CFG, 0);
    join
    finish_test("cfg_regs", base);

    base = tb_errs + chk_errs;
    fork
      run_source(0, N_MEM, 1);
      run_source(1, N_MEM, 1);
    join
    finish_test("memory_routing", base);

    base  = tb_errs + chk_errs;
    resps = chk_resps;
    fork
      run_source(0, N_SHR, 2);
      run_source(1, N_SHR, 2);
    join
    if (chk_resps - resps != 2 * N_SHR)
    begin
      $display("ERROR at %0t: %0d responses seen for %0d commands", $time,
               chk_resps - resps, 2 * N_SHR);
      tb_errs++;
    end
    finish_test("shared_sink", base);

    base = tb_errs + chk_errs;
    issue(0, OP_WRITE, CLINT_BASE, 64'd1);
    @(negedge clk);
    expect_bit("software_irq_o", 1'b1, software_irq);
    issue(0, OP_WRITE, CLINT_BASE, 64'd0);
    @(negedge clk);
    expect_bit("software_irq_o", 1'b0, software_irq);
    issue(0, OP_WRITE, CLINT_BASE | 32'h4000, 64'd16);
    risen = 1'b0;
    for (int k = 0; k < 20 && !risen; k++)
    begin
      @(negedge clk);
      risen = timer_irq;
    end
    if (!risen)
    begin
      $display("ERROR at %0t: timer interrupt did not rise", $time);
      tb_errs++;
    end
    issue(0, OP_WRITE, CLINT_BASE | 32'h4000, '1);
    @(negedge clk);
    expect_bit("timer_irq_o", 1'b0, timer_irq);
    issue(0, OP_READ, CLINT_BASE | 32'h4000, '0);
    issue(0, OP_WRITE, CLINT_BASE, 64'd1);
    issue(0, OP_READ, CLINT_BASE, '0);
    issue(0, OP_WRITE, CLINT_BASE, 64'd0);
    issue(0, OP_READ, CLINT_BASE | 32'hBFF8, '0);
    issue(0, OP_READ, CLINT_BASE | 32'hBFF8, '0);
    finish_test("clint_irq", base);

    $display("%0d of %0d tests passed, %0d errors", n_pass, n_tests, tb_errs + chk_errs);
    if (tb_errs + chk_errs == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

//--- flist.f
common/uncore_pkg.sv
xbar/rr_arbiter.sv
xbar/msg_xbar.sv
src/addr_decode.sv
devices/cfg_regs.sv
devices/clint.sv
src/uncore_top.sv
dv/tb_checker.sv
dv/tb_uncore.sv

//--- run.sh
#!/bin/sh
# Build and run the uncore testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_uncore -o tb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "compile failed with status $status"
  exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "RESULT: PASS"; then
  exit 0
fi
exit 1
